// File: src.f
+incdir+source
source/blake_pkg.sv
source/blake_job_if.sv
source/blake_g_mix.sv
source/blake_job_loader.sv
source/blake_job_queue.sv
source/blake_round_engine.sv
source/blake_core.sv
testbench/blake_core_assert.sv
testbench/blake_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the BLAKE core testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module blake_core_tb -f src.f -o blake_core_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/blake_core_sim +verilator+error+limit+1000 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
fi

if grep -qx "Testbench passed" "$LOG"; then
   exit 0
fi
exit 1

// File: testbench/blake_core_tb.sv
// BLAKE-256 core testbench
// random jobs against a software model, match rule and result back-pressure
`timescale 1ns/100ps
`include "blake_params.svh"

module blake_core_tb import blake_pkg::*; ();

   localparam int WAIT_LIMIT = 5000;

   logic                       clk;
   logic                       reset_i;
   logic                       req_i;
   logic [8*`BLAKE_WORD_W-1:0] midstate_i;
   logic [3*`BLAKE_WORD_W-1:0] data_i;
   word_t                      nonce_i;
   word_t                      target_i;
   logic                       ack_o;
   logic                       res_req_o;
   word_t                      hash7_o;
   logic                       match_o;
   logic                       res_ack_i;

   logic [8*`BLAKE_WORD_W-1:0] job_ms [$];
   logic [3*`BLAKE_WORD_W-1:0] job_dt [$];
   word_t                      job_nonce [$];
   word_t                      job_tgt [$];
   word_t                      exp_hash [$];
   logic                       exp_match [$];
   int                         tests = 0;
   int                         checks = 0;
   int                         errors = 0;
   int                         timeouts = 0;

   blake_core DUT (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic word_t rotr(word_t x, int n);
      return (x >> n) | (x << (`BLAKE_WORD_W - n));
   endfunction

   // straight BLAKE-256 compression of the last block, 8 G calls per round
   function automatic word_t model_hash7(logic [255:0] ms, logic [95:0] dt, word_t nonce);
      word_t      v [16];
      word_t      m [16];
      int         a, b, c, d;
      logic [3:0] s0, s1;
      for (int i = 0; i < 16; i++) begin
         m[i] = '0;
      end
      for (int i = 0; i < 3; i++) begin
         m[i] = dt[i*32 +: 32];
      end
      m[3]  = nonce;
      m[4]  = 32'h80000000;
      m[13] = 32'h1;
      m[15] = 32'h280;
      for (int i = 0; i < 8; i++) begin
         v[i] = ms[i*32 +: 32];
      end
      for (int i = 0; i < 4; i++) begin
         v[8 + i] = blake_const[i];
      end
      v[12] = blake_const[4] ^ 32'h280;
      v[13] = blake_const[5] ^ 32'h280;
      v[14] = blake_const[6];
      v[15] = blake_const[7];
      for (int r = 0; r < `BLAKE_ROUNDS; r++) begin
         for (int i = 0; i < 8; i++) begin
            if (i < 4) begin
               a = i;
               b = 4 + i;
               c = 8 + i;
               d = 12 + i;
            end else begin
               a = i - 4;
               b = 4 + (i - 3) % 4;
               c = 8 + (i - 2) % 4;
               d = 12 + (i - 1) % 4;
            end
            s0 = blake_sigma[r % 10][2*i];
            s1 = blake_sigma[r % 10][2*i + 1];
            v[a] = v[a] + v[b] + (m[s0] ^ blake_const[s1]);
            v[d] = rotr(v[d] ^ v[a], 16);
            v[c] = v[c] + v[d];
            v[b] = rotr(v[b] ^ v[c], 12);
            v[a] = v[a] + v[b] + (m[s1] ^ blake_const[s0]);
            v[d] = rotr(v[d] ^ v[a], 8);
            v[c] = v[c] + v[d];
            v[b] = rotr(v[b] ^ v[c], 7);
         end
      end
      return ms[7*32 +: 32] ^ v[7] ^ v[15];
   endfunction

   function automatic logic [255:0] random_block();
      logic [255:0] r;
      for (int i = 0; i < 8; i++) begin
         r[i*32 +: 32] = $urandom;
      end
      return r;
   endfunction

   function automatic logic [95:0] random_data();
      logic [95:0] r;
      for (int i = 0; i < 3; i++) begin
         r[i*32 +: 32] = $urandom;
      end
      return r;
   endfunction

   task automatic end_run();
      $display("tests %0d, checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
               tests, checks, errors, timeouts, DUT.u_assert.fail_cnt);
      if (errors == 0 && timeouts == 0 && DUT.u_assert.fail_cnt == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   endtask

   task automatic report_timeout(string what);
      $display("timeout while waiting for %s", what);
      timeouts++;
      end_run();
   endtask

   task automatic wait_ack(logic level);
      int n;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (ack_o != level && n < WAIT_LIMIT);
      if (ack_o != level) begin
         report_timeout(level ? "ack_o to rise" : "ack_o to fall");
      end
   endtask

   task automatic wait_res_req(logic level);
      int n;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (res_req_o != level && n < WAIT_LIMIT);
      if (res_req_o != level) begin
         report_timeout(level ? "res_req_o to rise" : "res_req_o to fall");
      end
   endtask

   task automatic add_job(logic [255:0] ms, logic [95:0] dt, word_t nonce, word_t tgt);
      word_t h;
      h = model_hash7(ms, dt, nonce);
      job_ms.push_back(ms);
      job_dt.push_back(dt);
      job_nonce.push_back(nonce);
      job_tgt.push_back(tgt);
      exp_hash.push_back(h);
      exp_match.push_back(h <= tgt);
   endtask

   // requests go out back to back, each one a full four-phase cycle
   task automatic issue_jobs();
      for (int k = 0; k < job_nonce.size(); k++) begin
         @(posedge clk);
         midstate_i <= job_ms[k];
         data_i     <= job_dt[k];
         nonce_i    <= job_nonce[k];
         target_i   <= job_tgt[k];
         req_i      <= 1'b1;
         wait_ack(1'b1);
         req_i <= 1'b0;
         wait_ack(1'b0);
      end
   endtask

   task automatic collect_results(int n, int max_delay);
      for (int k = 0; k < n; k++) begin
         wait_res_req(1'b1);
         repeat ($urandom_range(max_delay, 0)) @(posedge clk);
         checks += 2;
         assert (hash7_o == exp_hash[0]) else begin
            $display("Fail hash7_o expected %h got %h", exp_hash[0], hash7_o);
            errors++;
         end
         assert (match_o == exp_match[0]) else begin
            $display("Fail match_o expected %h got %h", exp_match[0], match_o);
            errors++;
         end
         void'(exp_hash.pop_front());
         void'(exp_match.pop_front());
         res_ack_i <= 1'b1;
         wait_res_req(1'b0);
         // ack may linger, the next result has to wait for its release
         repeat ($urandom_range(max_delay, 0)) @(posedge clk);
         res_ack_i <= 1'b0;
      end
   endtask

   task automatic run_jobs(int max_delay);
      int n;
      n = job_nonce.size();
      fork
         issue_jobs();
         collect_results(n, max_delay);
      join
      job_ms.delete();
      job_dt.delete();
      job_nonce.delete();
      job_tgt.delete();
      tests++;
   endtask

   initial begin
      logic [255:0] ms;
      logic [95:0]  dt;
      word_t        nonce;
      word_t        h;
      logic         extra;
      void'($urandom(32'ha90f7f68));
      reset_i    <= 1'b1;
      req_i      <= 1'b0;
      res_ack_i  <= 1'b0;
      midstate_i <= '0;
      data_i     <= '0;
      nonce_i    <= '0;
      target_i   <= '0;
      repeat (8) @(posedge clk);
      reset_i <= 1'b0;
      @(posedge clk);
      checks++;
      assert (!ack_o && !res_req_o) else begin
         $display("Fail ack_o/res_req_o expected 0/0 got %h/%h", ack_o, res_req_o);
         errors++;
      end
      tests++;
      $display("test reset_idle done, errors so far %0d", errors);

      for (int k = 0; k < 20; k++) begin
         add_job(random_block(), random_data(), $urandom, $urandom);
      end
      run_jobs(0);
      $display("test random_jobs done, errors so far %0d", errors);

      // target equal to hash7 must match, one below must not
      for (int k = 0; k < 6; k++) begin
         ms    = random_block();
         dt    = random_data();
         nonce = $urandom;
         h     = model_hash7(ms, dt, nonce);
         add_job(ms, dt, nonce, h);
         if (h != 0) begin
            add_job(ms, dt, nonce, h - 1);
         end
      end
      run_jobs(0);
      $display("test match_rule done, errors so far %0d", errors);

      for (int k = 0; k < 12; k++) begin
         add_job(random_block(), random_data(), $urandom, $urandom);
      end
      run_jobs(40);
      extra = 1'b0;
      repeat (60) begin
         @(posedge clk);
         extra = extra | res_req_o;
      end
      checks++;
      assert (!extra) else begin
         $display("a result appeared after every job had been answered");
         errors++;
      end
      $display("test back_pressure done, errors so far %0d", errors);
      end_run();
   end

endmodule

// File: testbench/blake_core_assert.sv
// BLAKE core protocol checks
// reset, handshake, match and queue bound assertions bound into the core
`timescale 1ns/100ps
`include "blake_params.svh"

module blake_core_assert import blake_pkg::*; (
   input logic                                      clk,
   input logic                                      reset_i,
   input logic                                      req_i,
   input logic                                      ack_o,
   input logic                                      res_req_o,
   input logic                                      res_ack_i,
   input word_t                                     hash7_o,
   input logic                                      match_o,
   input word_t                                     target_q_i,
   input logic [$clog2(`BLAKE_QUEUE_DEPTH+1)-1:0]   queue_count_i
);

   int fail_cnt = 0;

   a_reset_idle: assert property (@(posedge clk) reset_i |=> !ack_o && !res_req_o)
      else begin
         $error("ack_o or res_req_o high after reset");
         fail_cnt++;
      end

   // ack only answers a request
   a_ack_needs_req: assert property (@(posedge clk) disable iff (reset_i)
      !ack_o && !req_i |=> !ack_o)
      else begin
         $error("ack_o rose without req_i");
         fail_cnt++;
      end

   a_res_hold: assert property (@(posedge clk) disable iff (reset_i)
      res_req_o && !res_ack_i |=> res_req_o && $stable(hash7_o) && $stable(match_o))
      else begin
         $error("result dropped or changed before res_ack_i");
         fail_cnt++;
      end

   a_res_no_rise: assert property (@(posedge clk) disable iff (reset_i)
      !res_req_o && res_ack_i |=> !res_req_o)
      else begin
         $error("res_req_o rose while res_ack_i was high");
         fail_cnt++;
      end

   a_match_rule: assert property (@(posedge clk) disable iff (reset_i)
      res_req_o |-> match_o == (hash7_o <= target_q_i))
      else begin
         $error("match_o disagrees with hash7_o and target");
         fail_cnt++;
      end

   a_queue_bound: assert property (@(posedge clk) disable iff (reset_i)
      queue_count_i <= `BLAKE_QUEUE_DEPTH)
      else begin
         $error("job queue count above its depth");
         fail_cnt++;
      end

endmodule

bind blake_core blake_core_assert u_assert (
   .clk(clk), .reset_i(reset_i), .req_i(req_i), .ack_o(ack_o),
   .res_req_o(res_req_o), .res_ack_i(res_ack_i), .hash7_o(hash7_o), .match_o(match_o),
   .target_q_i(u_engine.target_q), .queue_count_i(u_queue.count)
);

// File: source/blake_core.sv
// BLAKE-256 nonce-checking core
// loader, two-entry job queue and iterative round engine behind four-phase ports
`timescale 1ns/100ps
`include "blake_params.svh"

module blake_core import blake_pkg::*; (
   input  logic                       clk,
   input  logic                       reset_i,
   input  logic                       req_i,
   input  logic [8*`BLAKE_WORD_W-1:0] midstate_i,
   input  logic [3*`BLAKE_WORD_W-1:0] data_i,
   input  word_t                      nonce_i,
   input  word_t                      target_i,
   output logic                       ack_o,
   output logic                       res_req_o,
   output word_t                      hash7_o,
   output logic                       match_o,
   input  logic                       res_ack_i
);

   // loader to queue, queue to engine
   blake_job_if load_if ();
   blake_job_if eng_if ();

   blake_job_loader u_loader (
      .clk       (clk),
      .reset_i   (reset_i),
      .req_i     (req_i),
      .midstate_i(midstate_i),
      .data_i    (data_i),
      .nonce_i   (nonce_i),
      .target_i  (target_i),
      .ack_o     (ack_o),
      .job_o     (load_if.source)
   );

   blake_job_queue u_queue (
      .clk    (clk),
      .reset_i(reset_i),
      .in_o   (load_if.sink),
      .out_o  (eng_if.source)
   );

   blake_round_engine #(.ROUNDS(`BLAKE_ROUNDS)) u_engine (
      .clk      (clk),
      .reset_i  (reset_i),
      .job_i    (eng_if.sink),
      .res_req_o(res_req_o),
      .res_ack_i(res_ack_i),
      .hash7_o  (hash7_o),
      .match_o  (match_o)
   );

endmodule

// File: source/blake_round_engine.sv
// BLAKE-256 round engine
// iterative compression at one half-round per cycle, then hash7 and target compare
`timescale 1ns/100ps
`include "blake_params.svh"

module blake_round_engine import blake_pkg::*; #(
   parameter int ROUNDS = `BLAKE_ROUNDS
) (
   input  logic      clk,
   input  logic      reset_i,
   blake_job_if.sink job_i,
   output logic      res_req_o,
   input  logic      res_ack_i,
   output word_t     hash7_o,
   output logic      match_o
);

   localparam int STEPS  = 2 * ROUNDS;
   localparam int STEP_W = $clog2(STEPS);

   typedef enum logic [2:0] {E_IDLE, E_RUN, E_FINAL, E_RESP, E_WAIT} eng_state_t;

   eng_state_t        st;
   logic [STEP_W-1:0] step;
   logic [3:0]        sig_sel;
   logic              diag;
   logic              take;
   state_t            v;
   state_t            v_next;
   msg_t              m;
   word_t             iv7_q;
   word_t             target_q;
   word_t             hash7_w;
   word_t             ga [4], gb [4], gc [4], gd [4];
   word_t             gm0 [4], gm1 [4], gk0 [4], gk1 [4];
   word_t             oa [4], ob [4], oc [4], od [4];
   logic [3:0]        sel0 [4], sel1 [4];

   assign diag    = step[0];
   assign take    = (st == E_IDLE) && job_i.req && !job_i.ack;
   assign hash7_w = iv7_q ^ v[7] ^ v[15];

   // column step on even cycles, diagonal step on odd ones
   always_comb begin
      v_next = v;
      for (int g = 0; g < 4; g++) begin
         sel0[g] = blake_sigma[sig_sel][(diag ? 8 : 0) + 2*g];
         sel1[g] = blake_sigma[sig_sel][(diag ? 8 : 0) + 2*g + 1];
         gm0[g]  = m[sel0[g]];
         gk0[g]  = blake_const[sel1[g]];
         gm1[g]  = m[sel1[g]];
         gk1[g]  = blake_const[sel0[g]];
         ga[g]   = v[g];
         gb[g]   = diag ? v[4 + (g + 1) % 4]  : v[4 + g];
         gc[g]   = diag ? v[8 + (g + 2) % 4]  : v[8 + g];
         gd[g]   = diag ? v[12 + (g + 3) % 4] : v[12 + g];
         v_next[g] = oa[g];
         v_next[diag ? 4 + (g + 1) % 4  : 4 + g]  = ob[g];
         v_next[diag ? 8 + (g + 2) % 4  : 8 + g]  = oc[g];
         v_next[diag ? 12 + (g + 3) % 4 : 12 + g] = od[g];
      end
   end

   for (genvar g = 0; g < 4; g++) begin : g_mix
      blake_g_mix u_g (
         .a_i (ga[g]),  .b_i (gb[g]),  .c_i (gc[g]),  .d_i (gd[g]),
         .m0_i(gm0[g]), .m1_i(gm1[g]), .k0_i(gk0[g]), .k1_i(gk1[g]),
         .a_o (oa[g]),  .b_o (ob[g]),  .c_o (oc[g]),  .d_o (od[g])
      );
   end

   always_ff @(posedge clk) begin
      if (take) begin
         v        <= job_i.job.v_init;
         m        <= job_i.job.msg;
         iv7_q    <= job_i.job.iv7;
         target_q <= job_i.job.target;
      end else if (st == E_RUN) begin
         v <= v_next;
      end
      // finalization, held until the response is taken
      if (st == E_FINAL) begin
         hash7_o <= hash7_w;
         match_o <= (hash7_w <= target_q);
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         st        <= E_IDLE;
         step      <= '0;
         sig_sel   <= '0;
         job_i.ack <= 1'b0;
         res_req_o <= 1'b0;
      end else begin
         if (job_i.ack && !job_i.req) begin
            job_i.ack <= 1'b0;
         end
         case (st)
            E_IDLE: begin
               if (take) begin
                  job_i.ack <= 1'b1;
                  step      <= '0;
                  sig_sel   <= '0;
                  st        <= E_RUN;
               end
            end
            E_RUN: begin
               step <= step + 1'b1;
               if (diag) begin
                  sig_sel <= (sig_sel == 4'd9) ? 4'd0 : sig_sel + 4'd1;
               end
               if (step == STEP_W'(STEPS - 1)) begin
                  st <= E_FINAL;
               end
            end
            E_FINAL: begin
               res_req_o <= 1'b1;
               st        <= E_RESP;
            end
            E_RESP: begin
               if (res_ack_i) begin
                  res_req_o <= 1'b0;
                  st        <= E_WAIT;
               end
            end
            default: begin
               // next job only once the result ack is back low
               if (!res_ack_i) begin
                  st <= E_IDLE;
               end
            end
         endcase
      end
   end

endmodule

// File: source/blake_job_queue.sv
// BLAKE job queue
// small circular buffer between the loader and the round engine
`timescale 1ns/100ps
`include "blake_params.svh"

module blake_job_queue import blake_pkg::*; (
   input  logic       clk,
   input  logic       reset_i,
   blake_job_if.sink  in_o,
   blake_job_if.source out_o
);

   localparam int DEPTH = `BLAKE_QUEUE_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   job_t             mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             push;
   logic             pop;

   assign full = (count == CNT_W'(DEPTH));
   // no ack while full, the loader then waits
   assign push = in_o.req && !in_o.ack && !full;
   assign pop  = out_o.req && out_o.ack;

   // oldest entry is always on the output
   assign out_o.job = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_o.job;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         in_o.ack  <= 1'b0;
         out_o.req <= 1'b0;
      end else begin
         // sink side
         if (push) begin
            in_o.ack <= 1'b1;
            wr_ptr   <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end else if (in_o.ack && !in_o.req) begin
            in_o.ack <= 1'b0;
         end
         // source side
         if (pop) begin
            out_o.req <= 1'b0;
            rd_ptr    <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end else if (!out_o.req && !out_o.ack && (count != '0)) begin
            out_o.req <= 1'b1;
         end
         count <= count + CNT_W'(push) - CNT_W'(pop);
      end
   end

endmodule

// File: source/blake_job_loader.sv
// BLAKE job loader
// takes a top-level request and builds the final message block and initial state
`timescale 1ns/100ps
`include "blake_params.svh"

module blake_job_loader import blake_pkg::*; (
   input  logic                       clk,
   input  logic                       reset_i,
   input  logic                       req_i,
   input  logic [8*`BLAKE_WORD_W-1:0] midstate_i,
   input  logic [3*`BLAKE_WORD_W-1:0] data_i,
   input  word_t                      nonce_i,
   input  word_t                      target_i,
   output logic                       ack_o,
   blake_job_if.source                job_o
);

   localparam word_t BLOCK_BITS = word_t'(32'h280);

   typedef enum logic [1:0] {L_IDLE, L_OFFER, L_DONE} load_state_t;

   load_state_t st;
   job_t        job_next;
   logic        take;

   assign take = (st == L_IDLE) && req_i && !ack_o;

   // padding and counter words follow the 80-byte header layout
   always_comb begin
      job_next = '0;
      for (int i = 0; i < 8; i++) begin
         job_next.v_init[i]     = midstate_i[i*`BLAKE_WORD_W +: `BLAKE_WORD_W];
         job_next.v_init[8 + i] = blake_const[i];
      end
      job_next.v_init[12] = blake_const[4] ^ BLOCK_BITS;
      job_next.v_init[13] = blake_const[5] ^ BLOCK_BITS;
      for (int i = 0; i < 3; i++) begin
         job_next.msg[i] = data_i[i*`BLAKE_WORD_W +: `BLAKE_WORD_W];
      end
      job_next.msg[3]  = nonce_i;
      job_next.msg[4]  = word_t'(32'h80000000);
      job_next.msg[13] = word_t'(1);
      job_next.msg[15] = BLOCK_BITS;
      job_next.iv7     = job_next.v_init[7];
      job_next.target  = target_i;
   end

   always_ff @(posedge clk) begin
      if (take) begin
         job_o.job <= job_next;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         st        <= L_IDLE;
         ack_o     <= 1'b0;
         job_o.req <= 1'b0;
      end else begin
         if (ack_o && !req_i) begin
            ack_o <= 1'b0;
         end
         case (st)
            L_IDLE: begin
               if (take) begin
                  ack_o <= 1'b1;
                  st    <= L_OFFER;
               end
            end
            // req goes up the cycle after ack_o
            L_OFFER: begin
               if (!job_o.req) begin
                  job_o.req <= 1'b1;
               end else if (job_o.ack) begin
                  job_o.req <= 1'b0;
                  st        <= L_DONE;
               end
            end
            default: begin
               if (!job_o.ack) begin
                  st <= L_IDLE;
               end
            end
         endcase
      end
   end

endmodule

// File: source/blake_g_mix.sv
// BLAKE-256 G function
// mixes four state words with two message words, purely combinational
`timescale 1ns/100ps

module blake_g_mix import blake_pkg::*; (
   input  word_t a_i,
   input  word_t b_i,
   input  word_t c_i,
   input  word_t d_i,
   input  word_t m0_i,
   input  word_t m1_i,
   input  word_t k0_i,
   input  word_t k1_i,
   output word_t a_o,
   output word_t b_o,
   output word_t c_o,
   output word_t d_o
);

   function automatic word_t ror(word_t x, int n);
      return (x >> n) | (x << ($bits(word_t) - n));
   endfunction

   word_t a1, b1, c1, d1;

   // first half with m0, rotations 16 and 12
   assign a1 = a_i + b_i + (m0_i ^ k0_i);
   assign d1 = ror(d_i ^ a1, 16);
   assign c1 = c_i + d1;
   assign b1 = ror(b_i ^ c1, 12);

   // second half with m1, rotations 8 and 7
   assign a_o = a1 + b1 + (m1_i ^ k1_i);
   assign d_o = ror(d1 ^ a_o, 8);
   assign c_o = c1 + d_o;
   assign b_o = ror(b1 ^ c_o, 7);

endmodule

// File: source/blake_job_if.sv
// BLAKE job link
// four-phase req/ack channel carrying one job
`timescale 1ns/100ps

interface blake_job_if import blake_pkg::*; ();

   logic req;
   logic ack;
   job_t job;

   // job must be stable while req is high
   modport source (
      output req,
      output job,
      input  ack
   );

   modport sink (
      input  req,
      input  job,
      output ack
   );

endinterface

// File: source/blake_pkg.sv
// BLAKE-256 types and tables
// word, state, message and job types plus the constant and sigma tables
`include "blake_params.svh"

package blake_pkg;

   typedef logic [`BLAKE_WORD_W-1:0] word_t;
   typedef word_t [`BLAKE_MSG_WORDS-1:0] state_t;
   typedef word_t [`BLAKE_MSG_WORDS-1:0] msg_t;

   // one nonce check, ready for compression
   typedef struct packed {
      state_t v_init;
      msg_t   msg;
      word_t  iv7;
      word_t  target;
   } job_t;

   localparam word_t blake_const [`BLAKE_MSG_WORDS] = '{
      32'h243F6A88, 32'h85A308D3, 32'h13198A2E, 32'h03707344,
      32'hA4093822, 32'h299F31D0, 32'h082EFA98, 32'hEC4E6C89,
      32'h452821E6, 32'h38D01377, 32'hBE5466CF, 32'h34E90C6C,
      32'hC0AC29B7, 32'hC97C50DD, 32'h3F84D5B5, 32'hB5470917
   };

   // message permutations, round r uses entry r mod 10
   localparam logic [3:0] blake_sigma [10][16] = '{
      '{ 0,  1,  2,  3,  4,  5,  6,  7,  8,  9, 10, 11, 12, 13, 14, 15},
      '{14, 10,  4,  8,  9, 15, 13,  6,  1, 12,  0,  2, 11,  7,  5,  3},
      '{11,  8, 12,  0,  5,  2, 15, 13, 10, 14,  3,  6,  7,  1,  9,  4},
      '{ 7,  9,  3,  1, 13, 12, 11, 14,  2,  6,  5, 10,  4,  0, 15,  8},
      '{ 9,  0,  5,  7,  2,  4, 10, 15, 14,  1, 11, 12,  6,  8,  3, 13},
      '{ 2, 12,  6, 10,  0, 11,  8,  3,  4, 13,  7,  5, 15, 14,  1,  9},
      '{12,  5,  1, 15, 14, 13,  4, 10,  0,  7,  6,  3,  9,  2,  8, 11},
      '{13, 11,  7, 14, 12,  1,  3,  9,  5,  0, 15,  4,  8,  6,  2, 10},
      '{ 6, 15, 14,  9, 11,  3,  0,  8, 12,  2, 13,  7,  1,  4, 10,  5},
      '{10,  2,  8,  4,  7,  6,  1,  5, 15, 11,  9, 14,  3, 12, 13,  0}
   };

endpackage

// File: source/blake_params.svh
// BLAKE-256 core parameters
// word width, round count, block size and job queue depth
`ifndef BLAKE_PARAMS_SVH
`define BLAKE_PARAMS_SVH

// state and message word width
`define BLAKE_WORD_W 32

// compression rounds, reduced count used by the miner
`define BLAKE_ROUNDS 8

// words in the message block and in the working state
`define BLAKE_MSG_WORDS 16

// entries in the job queue
`define BLAKE_QUEUE_DEPTH 2

`endif
